// File: id_settings.svh
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// datapath
`define ID_DATA_W       32
`define ID_REG_ADDR_W   5
`define ID_NUM_RD_PORTS 2

// instruction word fields
`define ID_OPCODE_W     6
`define ID_FUNCT_W      6
`define ID_SHAMT_W      5
`define ID_IMM_W        16

// control fields towards execute
`define ID_ALUOP_W      8
`define ID_ALUSEL_W     3

`endif

// File: id_pkg.sv
`include "id_settings.svh"

package id_pkg;

    typedef logic [`ID_DATA_W-1:0]     word_t;
    typedef logic [`ID_REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes
    typedef enum logic [`ID_OPCODE_W-1:0] {
        OP_SPECIAL = 6'b000000,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    // function codes under SPECIAL
    typedef enum logic [`ID_FUNCT_W-1:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111
    } funct_e;

    typedef enum logic [`ID_ALUOP_W-1:0] {
        ALU_NOP = 8'b00000000,
        ALU_SRL = 8'b00000010,
        ALU_SRA = 8'b00000011,
        ALU_AND = 8'b00100100,
        ALU_OR  = 8'b00100101,
        ALU_XOR = 8'b00100110,
        ALU_NOR = 8'b00100111,
        ALU_SLL = 8'b01111100
    } aluop_e;

    typedef enum logic [`ID_ALUSEL_W-1:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010
    } alusel_e;

    typedef struct packed {
        opcode_e                opcode;
        reg_addr_t              rs;
        reg_addr_t              rt;
        reg_addr_t              rd;
        logic [`ID_SHAMT_W-1:0] shamt;
        funct_e                 funct;
    } r_inst_t;

    typedef struct packed {
        opcode_e              opcode;
        reg_addr_t            rs;
        reg_addr_t            rt;
        logic [`ID_IMM_W-1:0] imm16;
    } i_inst_t;

    // same 32-bit word seen as R-type or I-type
    typedef union packed {
        r_inst_t r;
        i_inst_t i;
    } inst_u;

endpackage

// File: id_decoder.sv
`timescale 1ns/10ps
`include "id_settings.svh"

module id_decoder import id_pkg::*; (
    input  inst_u                           inst_i,
    output logic [`ID_NUM_RD_PORTS-1:0]     re_o,
    output reg_addr_t [`ID_NUM_RD_PORTS-1:0] raddr_o,
    output word_t                           imm_o,
    output aluop_e                          aluop_o,
    output alusel_e                         alusel_o,
    output reg_addr_t                       wd_o,
    output logic                            wreg_o,
    output logic                            invalid_o
);

    logic top_zero;
    logic shift_imm;

    // sll/srl/sra carry zeros in opcode and rs
    assign top_zero  = ({inst_i.r.opcode, inst_i.r.rs} == '0);
    assign shift_imm = top_zero && ((inst_i.r.funct == FN_SLL) ||
                                    (inst_i.r.funct == FN_SRL) ||
                                    (inst_i.r.funct == FN_SRA));

    always_comb begin
        re_o       = '0;
        raddr_o[0] = inst_i.r.rs;
        raddr_o[1] = inst_i.r.rt;
        imm_o      = '0;
        aluop_o    = ALU_NOP;
        alusel_o   = SEL_NOP;
        wd_o       = inst_i.r.rd;
        wreg_o     = 1'b0;
        invalid_o  = 1'b1;

        case (inst_i.r.opcode)
            OP_SPECIAL: begin
                case (inst_i.r.funct)
                    FN_OR: begin
                        aluop_o  = ALU_OR;
                        alusel_o = SEL_LOGIC;
                    end
                    FN_AND: begin
                        aluop_o  = ALU_AND;
                        alusel_o = SEL_LOGIC;
                    end
                    FN_XOR: begin
                        aluop_o  = ALU_XOR;
                        alusel_o = SEL_LOGIC;
                    end
                    FN_NOR: begin
                        aluop_o  = ALU_NOR;
                        alusel_o = SEL_LOGIC;
                    end
                    FN_SLLV: begin
                        aluop_o  = ALU_SLL;
                        alusel_o = SEL_SHIFT;
                    end
                    FN_SRLV: begin
                        aluop_o  = ALU_SRL;
                        alusel_o = SEL_SHIFT;
                    end
                    FN_SRAV: begin
                        aluop_o  = ALU_SRA;
                        alusel_o = SEL_SHIFT;
                    end
                    default: begin
                    end
                endcase
                // register-register forms read rs and rt and write rd
                if (alusel_o != SEL_NOP) begin
                    re_o      = '1;
                    wreg_o    = 1'b1;
                    invalid_o = 1'b0;
                end
            end
            OP_ORI, OP_ANDI, OP_XORI, OP_LUI: begin
                case (inst_i.i.opcode)
                    OP_ANDI: aluop_o = ALU_AND;
                    OP_XORI: aluop_o = ALU_XOR;
                    default: aluop_o = ALU_OR;
                endcase
                alusel_o  = SEL_LOGIC;
                re_o[0]   = 1'b1;
                wd_o      = inst_i.i.rt;
                wreg_o    = 1'b1;
                invalid_o = 1'b0;
                if (inst_i.i.opcode == OP_LUI) begin
                    imm_o = {inst_i.i.imm16, {(`ID_DATA_W-`ID_IMM_W){1'b0}}};
                end else begin
                    imm_o = {{(`ID_DATA_W-`ID_IMM_W){1'b0}}, inst_i.i.imm16};
                end
            end
            default: begin
            end
        endcase

        // shift by shamt reads rt on port 1 and puts shamt in operand 1
        if (shift_imm) begin
            case (inst_i.r.funct)
                FN_SRL:  aluop_o = ALU_SRL;
                FN_SRA:  aluop_o = ALU_SRA;
                default: aluop_o = ALU_SLL;
            endcase
            alusel_o  = SEL_SHIFT;
            re_o      = '0;
            re_o[1]   = 1'b1;
            imm_o     = {{(`ID_DATA_W-`ID_SHAMT_W){1'b0}}, inst_i.r.shamt};
            wd_o      = inst_i.r.rd;
            wreg_o    = 1'b1;
            invalid_o = 1'b0;
        end
    end

endmodule

// File: id_operand_sel.sv
`timescale 1ns/10ps

module id_operand_sel import id_pkg::*; (
    input  logic      re_i,
    input  reg_addr_t raddr_i,
    input  word_t     rdata_i,
    input  word_t     imm_i,
    input  logic      ex_wreg_i,
    input  reg_addr_t ex_wd_i,
    input  word_t     ex_wdata_i,
    input  logic      mem_wreg_i,
    input  reg_addr_t mem_wd_i,
    input  word_t     mem_wdata_i,
    output word_t     operand_o
);

    logic ex_hit;
    logic mem_hit;

    // r0 is forwarded like any other register
    assign ex_hit  = ex_wreg_i && (ex_wd_i == raddr_i);
    assign mem_hit = mem_wreg_i && (mem_wd_i == raddr_i);

    always_comb begin
        if (!re_i) begin
            operand_o = imm_i;
        end else if (ex_hit) begin
            operand_o = ex_wdata_i;
        end else if (mem_hit) begin
            operand_o = mem_wdata_i;
        end else begin
            operand_o = rdata_i;
        end
    end

endmodule

// File: id_ex_reg.sv
`timescale 1ns/10ps

module id_ex_reg import id_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    input  aluop_e    aluop_i,
    input  alusel_e   alusel_i,
    input  reg_addr_t wd_i,
    input  logic      wreg_i,
    input  logic      invalid_i,
    input  word_t     reg1_i,
    input  word_t     reg2_i,
    output aluop_e    aluop_o,
    output alusel_e   alusel_o,
    output reg_addr_t wd_o,
    output logic      wreg_o,
    output logic      invalid_o,
    output word_t     reg1_o,
    output word_t     reg2_o
);

    // control fields reset to a bubble
    always_ff @(posedge clk) begin
        if (rst_i) begin
            aluop_o   <= ALU_NOP;
            alusel_o  <= SEL_NOP;
            wd_o      <= '0;
            wreg_o    <= 1'b0;
            invalid_o <= 1'b0;
        end else begin
            aluop_o   <= aluop_i;
            alusel_o  <= alusel_i;
            wd_o      <= wd_i;
            wreg_o    <= wreg_i;
            invalid_o <= invalid_i;
        end
    end

    // operands
    always_ff @(posedge clk) begin
        if (rst_i) begin
            reg1_o <= '0;
            reg2_o <= '0;
        end else begin
            reg1_o <= reg1_i;
            reg2_o <= reg2_i;
        end
    end

endmodule

// File: id_stage.sv
`timescale 1ns/10ps
`include "id_settings.svh"

module id_stage import id_pkg::*; (
    input  logic                             clk,
    input  logic                             rst_i,
    input  inst_u                            inst_i,
    input  word_t [`ID_NUM_RD_PORTS-1:0]     reg_rdata_i,
    input  logic                             ex_wreg_i,
    input  reg_addr_t                        ex_wd_i,
    input  word_t                            ex_wdata_i,
    input  logic                             mem_wreg_i,
    input  reg_addr_t                        mem_wd_i,
    input  word_t                            mem_wdata_i,
    output logic [`ID_NUM_RD_PORTS-1:0]      reg_re_o,
    output reg_addr_t [`ID_NUM_RD_PORTS-1:0] reg_raddr_o,
    output aluop_e                           aluop_o,
    output alusel_e                          alusel_o,
    output word_t                            reg1_o,
    output word_t                            reg2_o,
    output reg_addr_t                        wd_o,
    output logic                             wreg_o,
    output logic                             inst_invalid_o
);

    word_t                        imm;
    aluop_e                       dec_aluop;
    alusel_e                      dec_alusel;
    reg_addr_t                    dec_wd;
    logic                         dec_wreg;
    logic                         dec_invalid;
    word_t [`ID_NUM_RD_PORTS-1:0] operand;

    id_decoder i_id_decoder (
        .inst_i    (inst_i),
        .re_o      (reg_re_o),
        .raddr_o   (reg_raddr_o),
        .imm_o     (imm),
        .aluop_o   (dec_aluop),
        .alusel_o  (dec_alusel),
        .wd_o      (dec_wd),
        .wreg_o    (dec_wreg),
        .invalid_o (dec_invalid)
    );

    // one selector per read port
    for (genvar p = 0; p < `ID_NUM_RD_PORTS; p++) begin : g_sel
        id_operand_sel i_id_operand_sel (
            .re_i        (reg_re_o[p]),
            .raddr_i     (reg_raddr_o[p]),
            .rdata_i     (reg_rdata_i[p]),
            .imm_i       (imm),
            .ex_wreg_i   (ex_wreg_i),
            .ex_wd_i     (ex_wd_i),
            .ex_wdata_i  (ex_wdata_i),
            .mem_wreg_i  (mem_wreg_i),
            .mem_wd_i    (mem_wd_i),
            .mem_wdata_i (mem_wdata_i),
            .operand_o   (operand[p])
        );
    end

    id_ex_reg i_id_ex_reg (
        .clk       (clk),
        .rst_i     (rst_i),
        .aluop_i   (dec_aluop),
        .alusel_i  (dec_alusel),
        .wd_i      (dec_wd),
        .wreg_i    (dec_wreg),
        .invalid_i (dec_invalid),
        .reg1_i    (operand[0]),
        .reg2_i    (operand[1]),
        .aluop_o   (aluop_o),
        .alusel_o  (alusel_o),
        .wd_o      (wd_o),
        .wreg_o    (wreg_o),
        .invalid_o (inst_invalid_o),
        .reg1_o    (reg1_o),
        .reg2_o    (reg2_o)
    );

endmodule

// File: id_stage_checker.sv
`timescale 1ns/10ps

module id_stage_checker import id_pkg::*; (
    input logic    clk,
    input logic    rst_i,
    input aluop_e  aluop_i,
    input alusel_e alusel_i,
    input logic    wreg_i,
    input logic    invalid_i
);

    // register comes out of reset as a bubble
    a_reset_no_write: assert property (
        @(posedge clk) $past(rst_i) |-> !wreg_i
    ) else $error("wreg_o high in the cycle after reset");

    a_invalid_no_write: assert property (
        @(posedge clk) disable iff (rst_i) invalid_i |-> !wreg_i
    ) else $error("wreg_o high together with inst_invalid_o");

    // nop class and nop op only come together
    a_nop_pairing: assert property (
        @(posedge clk) disable iff (rst_i) ((alusel_i == SEL_NOP) == (aluop_i == ALU_NOP))
    ) else $error("alusel_o and aluop_o disagree on NOP");

endmodule

bind id_stage id_stage_checker i_id_stage_checker (
    .clk       (clk),
    .rst_i     (rst_i),
    .aluop_i   (aluop_o),
    .alusel_i  (alusel_o),
    .wreg_i    (wreg_o),
    .invalid_i (inst_invalid_o)
);

// File: tb_id_stage.sv
`timescale 1ns/10ps
`include "id_settings.svh"

module tb_id_stage import id_pkg::*; ();

    localparam int CLK_HALF        = 5;
    localparam int CLK_PERIOD      = 2 * CLK_HALF;
    localparam int RESET_CYCLES    = 10;
    localparam int NUM_INSTS       = 30;
    localparam int CYCLES_PER_INST = 2;
    localparam int MARGIN_CYCLES   = 40;
    localparam int WATCHDOG_NS     =
        (RESET_CYCLES + 2 + NUM_INSTS * CYCLES_PER_INST + MARGIN_CYCLES) * CLK_PERIOD;

    logic                             clk;
    logic                             rst;
    inst_u                            inst;
    word_t [`ID_NUM_RD_PORTS-1:0]     reg_rdata;
    logic                             ex_wreg;
    reg_addr_t                        ex_wd;
    word_t                            ex_wdata;
    logic                             mem_wreg;
    reg_addr_t                        mem_wd;
    word_t                            mem_wdata;
    logic [`ID_NUM_RD_PORTS-1:0]      reg_re;
    reg_addr_t [`ID_NUM_RD_PORTS-1:0] reg_raddr;
    aluop_e                           aluop;
    alusel_e                          alusel;
    word_t                            reg1;
    word_t                            reg2;
    reg_addr_t                        wd;
    logic                             wreg;
    logic                             inst_invalid;

    word_t rf [32];
    int    errors = 0;
    int    checks = 0;

    id_stage i_id_stage (
        .clk            (clk),
        .rst_i          (rst),
        .inst_i         (inst),
        .reg_rdata_i    (reg_rdata),
        .ex_wreg_i      (ex_wreg),
        .ex_wd_i        (ex_wd),
        .ex_wdata_i     (ex_wdata),
        .mem_wreg_i     (mem_wreg),
        .mem_wd_i       (mem_wd),
        .mem_wdata_i    (mem_wdata),
        .reg_re_o       (reg_re),
        .reg_raddr_o    (reg_raddr),
        .aluop_o        (aluop),
        .alusel_o       (alusel),
        .reg1_o         (reg1),
        .reg2_o         (reg2),
        .wd_o           (wd),
        .wreg_o         (wreg),
        .inst_invalid_o (inst_invalid)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    // register file answers in the same cycle
    always_comb begin
        for (int p = 0; p < `ID_NUM_RD_PORTS; p++) begin
            reg_rdata[p] = rf[reg_raddr[p]];
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic word_eq(string name, word_t exp, word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic addr_eq(string name, reg_addr_t exp, reg_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic aluop_eq(string name, aluop_e exp, aluop_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic alusel_eq(string name, alusel_e exp, alusel_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic flag_eq(string name, logic exp, logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    function automatic inst_u make_r(funct_e fn, reg_addr_t rs, reg_addr_t rt,
                                     reg_addr_t rd, logic [4:0] sa);
        inst_u w;
        w.r.opcode = OP_SPECIAL;
        w.r.rs     = rs;
        w.r.rt     = rt;
        w.r.rd     = rd;
        w.r.shamt  = sa;
        w.r.funct  = fn;
        return w;
    endfunction

    function automatic inst_u make_i(opcode_e op, reg_addr_t rs, reg_addr_t rt,
                                     logic [15:0] imm);
        inst_u w;
        w.i.opcode = op;
        w.i.rs     = rs;
        w.i.rt     = rt;
        w.i.imm16  = imm;
        return w;
    endfunction

    // new word on a rising edge and decode read back at the falling edge
    task automatic issue_inst(inst_u w, logic exw, reg_addr_t exd, word_t exdat,
                              logic memw, reg_addr_t memd, word_t memdat);
        @(posedge clk);
        inst      <= w;
        ex_wreg   <= exw;
        ex_wd     <= exd;
        ex_wdata  <= exdat;
        mem_wreg  <= memw;
        mem_wd    <= memd;
        mem_wdata <= memdat;
        @(negedge clk);
    endtask

    task automatic issue_plain(inst_u w);
        issue_inst(w, 1'b0, '0, '0, 1'b0, '0, '0);
    endtask

    task automatic settle();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic reads_check(logic [1:0] exp_re, reg_addr_t a0, reg_addr_t a1);
        flag_eq("reg_re_o[0]", exp_re[0], reg_re[0]);
        flag_eq("reg_re_o[1]", exp_re[1], reg_re[1]);
        if (exp_re[0]) begin
            addr_eq("reg_raddr_o[0]", a0, reg_raddr[0]);
        end
        if (exp_re[1]) begin
            addr_eq("reg_raddr_o[1]", a1, reg_raddr[1]);
        end
    endtask

    task automatic outputs_check(aluop_e op, alusel_e sel, reg_addr_t d,
                                 word_t r1, word_t r2);
        aluop_eq("aluop_o", op, aluop);
        alusel_eq("alusel_o", sel, alusel);
        addr_eq("wd_o", d, wd);
        flag_eq("wreg_o", 1'b1, wreg);
        flag_eq("inst_invalid_o", 1'b0, inst_invalid);
        word_eq("reg1_o", r1, reg1);
        word_eq("reg2_o", r2, reg2);
    endtask

    task automatic bubble_check();
        aluop_eq("aluop_o", ALU_NOP, aluop);
        alusel_eq("alusel_o", SEL_NOP, alusel);
        addr_eq("wd_o", '0, wd);
        flag_eq("wreg_o", 1'b0, wreg);
        flag_eq("inst_invalid_o", 1'b0, inst_invalid);
        word_eq("reg1_o", '0, reg1);
        word_eq("reg2_o", '0, reg2);
    endtask

    task automatic reset_bubble();
        bubble_check();
        issue_plain(make_r(FN_OR, 5'd1, 5'd2, 5'd3, 5'd0));
        settle();
        outputs_check(ALU_OR, SEL_LOGIC, 5'd3, rf[1], rf[2]);
        @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        bubble_check();
    endtask

    task automatic rtype_logic();
        funct_e    fns [4];
        aluop_e    ops [4];
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        fns = '{FN_OR, FN_AND, FN_XOR, FN_NOR};
        ops = '{ALU_OR, ALU_AND, ALU_XOR, ALU_NOR};
        for (int rep = 0; rep < 2; rep++) begin
            for (int k = 0; k < 4; k++) begin
                rs = 5'($urandom);
                rt = 5'($urandom);
                rd = 5'($urandom);
                issue_plain(make_r(fns[k], rs, rt, rd, 5'd0));
                reads_check(2'b11, rs, rt);
                settle();
                outputs_check(ops[k], SEL_LOGIC, rd, rf[rs], rf[rt]);
            end
        end
    endtask

    task automatic imm_logic();
        opcode_e     opc [4];
        aluop_e      ops [4];
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
        word_t       exp_imm;
        opc = '{OP_ORI, OP_ANDI, OP_XORI, OP_LUI};
        ops = '{ALU_OR, ALU_AND, ALU_XOR, ALU_OR};
        for (int k = 0; k < 4; k++) begin
            rs  = 5'($urandom);
            rt  = 5'($urandom);
            imm = 16'($urandom);
            // lui moves the immediate to the upper half
            exp_imm = (opc[k] == OP_LUI) ? {imm, 16'h0000} : {16'h0000, imm};
            issue_plain(make_i(opc[k], rs, rt, imm));
            reads_check(2'b01, rs, '0);
            settle();
            outputs_check(ops[k], SEL_LOGIC, rt, rf[rs], exp_imm);
        end
    endtask

    task automatic shifts();
        funct_e     fns [3];
        funct_e     vfns [3];
        aluop_e     ops [3];
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] sa;
        fns  = '{FN_SLL, FN_SRL, FN_SRA};
        vfns = '{FN_SLLV, FN_SRLV, FN_SRAV};
        ops  = '{ALU_SLL, ALU_SRL, ALU_SRA};
        for (int k = 0; k < 3; k++) begin
            rt = 5'($urandom);
            rd = 5'($urandom);
            sa = 5'($urandom);
            issue_plain(make_r(fns[k], 5'd0, rt, rd, sa));
            reads_check(2'b10, '0, rt);
            settle();
            outputs_check(ops[k], SEL_SHIFT, rd, {27'd0, sa}, rf[rt]);
        end
        for (int k = 0; k < 3; k++) begin
            rs = 5'($urandom);
            rt = 5'($urandom);
            rd = 5'($urandom);
            issue_plain(make_r(vfns[k], rs, rt, rd, 5'd0));
            reads_check(2'b11, rs, rt);
            settle();
            outputs_check(ops[k], SEL_SHIFT, rd, rf[rs], rf[rt]);
        end
    endtask

    task automatic forwarding();
        word_t xd;
        word_t md;
        xd = $urandom;
        md = $urandom;
        issue_inst(make_r(FN_OR, 5'd5, 5'd9, 5'd1, 5'd0), 1'b1, 5'd5, xd, 1'b1, 5'd5, md);
        settle();
        outputs_check(ALU_OR, SEL_LOGIC, 5'd1, xd, rf[9]);
        // execute writes elsewhere while memory hits rt
        issue_inst(make_r(FN_AND, 5'd5, 5'd9, 5'd2, 5'd0), 1'b1, 5'd12, xd, 1'b1, 5'd9, md);
        settle();
        outputs_check(ALU_AND, SEL_LOGIC, 5'd2, rf[5], md);
        issue_inst(make_r(FN_XOR, 5'd5, 5'd9, 5'd3, 5'd0), 1'b0, 5'd5, xd, 1'b0, 5'd9, md);
        settle();
        outputs_check(ALU_XOR, SEL_LOGIC, 5'd3, rf[5], rf[9]);
        // port 1 holds the immediate even though rt matches
        issue_inst(make_i(OP_ORI, 5'd5, 5'd9, 16'h00a5), 1'b1, 5'd9, xd, 1'b1, 5'd9, md);
        settle();
        outputs_check(ALU_OR, SEL_LOGIC, 5'd9, rf[5], 32'h0000_00a5);
        issue_inst(make_r(FN_SLL, 5'd0, 5'd9, 5'd4, 5'd7), 1'b1, 5'd0, xd, 1'b0, 5'd0, md);
        settle();
        outputs_check(ALU_SLL, SEL_SHIFT, 5'd4, 32'd7, rf[9]);
        // r0 takes forwarded data when it is read
        issue_inst(make_r(FN_NOR, 5'd0, 5'd9, 5'd5, 5'd0), 1'b0, 5'd0, xd, 1'b1, 5'd0, md);
        settle();
        outputs_check(ALU_NOR, SEL_LOGIC, 5'd5, md, rf[9]);
    endtask

    task automatic invalid_words();
        inst_u words [5];
        words[0] = make_i(opcode_e'(6'b001000), 5'd1, 5'd2, 16'h1234);
        words[1] = make_i(opcode_e'(6'b100011), 5'd3, 5'd4, 16'h0010);
        words[2] = make_i(opcode_e'(6'b000010), 5'd7, 5'd8, 16'hbeef);
        words[3] = make_r(funct_e'(6'b100000), 5'd2, 5'd3, 5'd4, 5'd0);
        // srl with rs set is not an immediate shift
        words[4] = make_r(FN_SRL, 5'd6, 5'd3, 5'd4, 5'd2);
        foreach (words[k]) begin
            issue_plain(words[k]);
            settle();
            flag_eq("inst_invalid_o", 1'b1, inst_invalid);
            flag_eq("wreg_o", 1'b0, wreg);
            aluop_eq("aluop_o", ALU_NOP, aluop);
            alusel_eq("alusel_o", SEL_NOP, alusel);
        end
    endtask

    initial begin
        void'($urandom(32'h373e));
        foreach (rf[a]) begin
            rf[a] = $urandom;
        end
        rst       <= 1'b1;
        inst      <= '0;
        ex_wreg   <= 1'b0;
        ex_wd     <= '0;
        ex_wdata  <= '0;
        mem_wreg  <= 1'b0;
        mem_wd    <= '0;
        mem_wdata <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        reset_bubble();
        rtype_logic();
        imm_logic();
        shifts();
        forwarding();
        invalid_words();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: id_stage.f
+incdir+.
id_pkg.sv
id_decoder.sv
id_operand_sel.sv
id_ex_reg.sv
id_stage.sv
id_stage_checker.sv
tb_id_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= id_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HEADERS := $(wildcard *.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
